// File: altair_bus.f
design/altair_bus_pkg.sv
design/local_bus_if.sv
design/sync_ram.sv
design/serial_uart.sv
design/acia_6850.sv
design/bus_decoder.sv
design/altair_bus_top.sv
sim/serial_line_model.sv
sim/altair_bus_tb.sv

// File: sim/altair_bus_tb.sv
`default_nettype none

module altair_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clks_per_bit = 8;
	localparam int frame_cycles = 10 * clks_per_bit;
	localparam int n_rand = 300;
	localparam int n_tx = 6;
	localparam int n_rx = 4;
	localparam int poll_limit = 4 * clks_per_bit;
	localparam int fill_count = 8192 + 256;
	// about eight cycles per apb transfer plus the serial frames
	localparam int run_cycles = (fill_count + 2 * n_rand + 64 + n_rx * (poll_limit + 2)) * 8 +
		(n_tx + n_rx + 2) * frame_cycles;
	localparam int watchdog_cycles = 2 * run_cycles + 20;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [16:0] paddr;
	logic [7:0] pwdata;
	wire logic [7:0] prdata;
	wire logic pready;
	wire logic rx;
	wire logic tx;

	integer seed;
	int error_count;
	int errors_before;
	int tests_run;
	int tests_failed;

	// reference model of the machine
	logic [7:0] main_model [0:8191];
	logic [7:0] stack_model [0:255];
	int boot_left;
	logic rx_full;

	altair_bus_top #(.CLKS_PER_BIT(clks_per_bit)) dut0 (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.rx      (rx),
		.tx      (tx)
	);

	serial_line_model #(.CLKS_PER_BIT(clks_per_bit)) line0 (
		.clk (clk),
		.tx  (tx),
		.rx  (rx)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// model functions
	// --------------------------------------------------
	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'ha5;
	endfunction

	function automatic logic is_serial_port(input logic [7:0] port);
		return (port == 8'h00) || (port == 8'h01) || (port == 8'h10) || (port == 8'h11);
	endfunction

	// reads wait for an idle transmitter, so tx empty always reads set
	function automatic logic [7:0] status_byte(input logic full);
		return {2'b00, full, 3'b000, 1'b1, full};
	endfunction

	function automatic logic [7:0] predict_read(input logic [15:0] a);
		if (boot_left > 0) begin
			boot_left--;
			case (boot_left)
				2:       return 8'hc3;
				1:       return 8'h00;
				default: return 8'hfd;
			endcase
		end
		if (a[15:13] == 3'b000)
			return main_model[a[12:0]];
		if (a[15:8] == 8'hfb)
			return stack_model[a[7:0]];
		return 8'hff; // unmapped, the 0xfd page too
	endfunction

	function automatic void record_write(input logic [15:0] a, input logic [7:0] d);
		if (a[15:13] == 3'b000)
			main_model[a[12:0]] = d;
		else if (a[15:8] == 8'hfb)
			stack_model[a[7:0]] = d;
	endfunction

	// --------------------------------------------------
	// apb master and checks
	// --------------------------------------------------
	task automatic apb_access(input logic write, input logic [16:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata);
		@(posedge clk);
		psel <= 1'b1; // setup phase
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (pready !== 1'b1)
			@(negedge clk);
		rdata = prdata;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_and_compare(input logic [16:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		apb_access(1'b0, addr, 8'h00, got);
		if (got !== exp) begin
			$display("[ERROR] prdata at 0x%05h: expected 0x%02h, got 0x%02h", addr, exp, got);
			error_count++;
		end
	endtask

	task automatic store_byte(input logic [16:0] addr, input logic [7:0] d);
		logic [7:0] unused;
		apb_access(1'b1, addr, d, unused);
		if (!addr[16])
			record_write(addr[15:0], d);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %0d (%s) ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d (%s) FAILED with %0d errors", tests_run, name,
				error_count - errors_before);
		end
		errors_before = error_count;
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	initial begin : stimulus
		logic [15:0] a;
		logic [15:0] b;
		logic [7:0] d;
		logic [7:0] got;
		logic [7:0] port;
		logic [7:0] mirror;
		logic [7:0] sent [0:n_tx-1];
		int i;
		int tries;
		seed = 47061;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		error_count = 0;
		errors_before = 0;
		tests_run = 0;
		tests_failed = 0;
		boot_left = 3;
		rx_full = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// boot overlay, a write and an io read in between must not advance it
		a = {3'b000, 13'($random(seed))};
		d = 8'($random(seed));
		store_byte({1'b0, a}, d);
		for (i = 0; i < 3; i++) begin
			b = 16'($random(seed));
			read_and_compare({1'b0, b}, predict_read(b));
			if (i == 0)
				read_and_compare({1'b1, 8'($random(seed)), 8'h00}, status_byte(rx_full));
		end
		read_and_compare({1'b0, a}, predict_read(a)); // overlay now off
		report_test("boot overlay");

		for (i = 0; i < 8192; i++)
			store_byte({1'b0, 3'b000, 13'(i)}, fill_byte(16'(i)));
		for (i = 0; i < 256; i++)
			store_byte({1'b0, 8'hfb, 8'(i)}, fill_byte({8'hfb, 8'(i)}));
		for (i = 0; i < n_rand; i++) begin
			case (2'($random(seed)))
				2'd0:    a = {3'b000, 13'($random(seed))};
				2'd1:    a = {8'hfb, 8'($random(seed))};
				2'd2:    a = {8'hfd, 8'($random(seed))};
				default: a = 16'($random(seed));
			endcase
			if (1'($random(seed))) begin
				d = 8'($random(seed));
				store_byte({1'b0, a}, d);
			end
			read_and_compare({1'b0, a}, predict_read(a));
		end
		report_test("memory map");

		read_and_compare({1'b1, 8'($random(seed)), 8'h00}, status_byte(rx_full));
		read_and_compare({1'b1, 8'($random(seed)), 8'h10}, status_byte(rx_full));
		for (i = 0; i < 16; i++) begin
			do
				port = 8'($random(seed));
			while (is_serial_port(port));
			read_and_compare({1'b1, 8'($random(seed)), port}, 8'hff);
		end
		report_test("io map and status");

		for (i = 0; i < n_tx; i++) begin
			port = i[0] ? 8'h11 : 8'h01;
			mirror = ((i % 4) < 2) ? port : 8'($random(seed));
			d = 8'($random(seed));
			sent[i] = d & 8'h7f; // 7-bit terminal
			store_byte({1'b1, mirror, port}, d);
			if (line0.cap_count != i) begin
				$display("data write %0d finished with %0d frames seen on tx instead of %0d",
					i, line0.cap_count, i);
				error_count++;
			end
		end
		tries = 0;
		while (line0.cap_count < n_tx && tries < 2 * frame_cycles) begin
			@(posedge clk);
			tries++;
		end
		if (line0.cap_count != n_tx) begin
			$display("only %0d of %0d frames arrived on tx", line0.cap_count, n_tx);
			error_count++;
		end
		for (i = 0; i < n_tx && i < line0.cap_count; i++) begin
			if (line0.cap_mem[i] !== sent[i]) begin
				$display("[ERROR] tx frame %0d: expected 0x%02h, got 0x%02h", i, sent[i],
					line0.cap_mem[i]);
				error_count++;
			end
		end
		if (line0.frame_errors != 0) begin
			$display("stop bit missing on tx in %0d frames", line0.frame_errors);
			error_count++;
		end
		report_test("serial transmit");

		for (i = 0; i < n_rx; i++) begin
			d = 8'($random(seed));
			line0.send_byte(d);
			rx_full = 1'b1;
			tries = 0;
			apb_access(1'b0, {1'b1, 8'h00, 8'h00}, 8'h00, got);
			while (got === status_byte(1'b0) && tries < poll_limit) begin
				apb_access(1'b0, {1'b1, 8'h00, 8'h00}, 8'h00, got);
				tries++;
			end
			if (got !== status_byte(rx_full)) begin
				$display("[ERROR] prdata status: expected 0x%02h, got 0x%02h",
					status_byte(rx_full), got);
				error_count++;
			end
			port = i[0] ? 8'h11 : 8'h01;
			read_and_compare({1'b1, 8'($random(seed)), port}, d);
			rx_full = 1'b0; // data read empties the receiver
			read_and_compare({1'b1, 8'($random(seed)), port & 8'hfe}, status_byte(rx_full));
		end
		report_test("serial receive");

		$display("summary: %0d run, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/serial_line_model.sv
`default_nettype none

// far end of the serial line, sends on rx and decodes frames from tx
module serial_line_model #(
	parameter int CLKS_PER_BIT = 16
) (
	input  wire logic clk,
	input  wire logic tx,
	output logic      rx
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] cap_mem [0:63]; // bytes seen on tx, in order
	int cap_count;
	int frame_errors;

	initial begin
		rx = 1'b1; // idle line
		cap_count = 0;
		frame_errors = 0;
	end

	// --------------------------------------------------
	// sender, one 8N1 frame
	// --------------------------------------------------
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		int i;
		frame = {1'b1, value, 1'b0}; // stop, data, start
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= frame[i]; // lsb first after the start bit
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
		@(posedge clk);
	endtask

	// --------------------------------------------------
	// receiver on tx, sampled near mid-bit
	// --------------------------------------------------
	initial begin : capture
		logic [7:0] shift;
		int b;
		forever begin
			@(negedge clk);
			if (tx === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				if (tx === 1'b0) begin // still low, a real start bit
					for (b = 0; b < 8; b++) begin
						repeat (CLKS_PER_BIT) @(negedge clk);
						shift[b] = tx;
					end
					repeat (CLKS_PER_BIT) @(negedge clk);
					if (tx !== 1'b1)
						frame_errors++; // stop bit missing
					if (cap_count < 64)
						cap_mem[cap_count] = shift;
					cap_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/altair_bus_top.sv
`default_nettype none

module altair_bus_top #(
	parameter int CLKS_PER_BIT = 16
) (
	input  wire logic                              clk,
	input  wire logic                              reset,

	// apb slave port, bit 16 of paddr picks I/O space
	input  wire logic                              psel,
	input  wire logic                              penable,
	input  wire logic                              pwrite,
	input  wire logic [altair_bus_pkg::addr_w:0]   paddr,
	input  wire logic [altair_bus_pkg::data_w-1:0] pwdata,
	output wire logic [altair_bus_pkg::data_w-1:0] prdata,
	output wire logic                              pready,

	// serial line
	input  wire logic                              rx,
	output wire logic                              tx
);

	local_bus_if #(.ADDR_WIDTH(altair_bus_pkg::main_addr_w)) main_bus ();
	local_bus_if #(.ADDR_WIDTH(altair_bus_pkg::stack_addr_w)) stack_bus ();
	local_bus_if #(.ADDR_WIDTH(1)) acia_bus (); // status / data

	bus_decoder decoder0 (
		.clk       (clk),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.main_bus  (main_bus),
		.stack_bus (stack_bus),
		.acia_bus  (acia_bus)
	);

	// 8k main memory
	sync_ram #(.ADDR_WIDTH(altair_bus_pkg::main_addr_w)) main_ram (
		.clk (clk),
		.bus (main_bus)
	);

	// stack page at 0xfb00
	sync_ram #(.ADDR_WIDTH(altair_bus_pkg::stack_addr_w)) stack_ram (
		.clk (clk),
		.bus (stack_bus)
	);

	acia_6850 #(.CLKS_PER_BIT(CLKS_PER_BIT)) acia0 (
		.clk   (clk),
		.reset (reset),
		.bus   (acia_bus),
		.rx    (rx),
		.tx    (tx)
	);

endmodule

`default_nettype wire

// File: design/bus_decoder.sv
`default_nettype none

module bus_decoder (
	input  wire logic                              clk,
	input  wire logic                              reset,
	input  wire logic                              psel,
	input  wire logic                              penable,
	input  wire logic                              pwrite,
	input  wire logic [altair_bus_pkg::addr_w:0]   paddr,
	input  wire logic [altair_bus_pkg::data_w-1:0] pwdata,
	output logic      [altair_bus_pkg::data_w-1:0] prdata,
	output logic                                   pready,
	local_bus_if.host                              main_bus,
	local_bus_if.host                              stack_bus,
	local_bus_if.host                              acia_bus
);

	// apb slave states
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_wait = 2'd1; // access phase, waiting on target
	localparam logic [1:0] st_resp = 2'd2;

	// read data source
	localparam logic [2:0] sel_none = 3'd0;
	localparam logic [2:0] sel_main = 3'd1;
	localparam logic [2:0] sel_stack = 3'd2;
	localparam logic [2:0] sel_acia = 3'd3;
	localparam logic [2:0] sel_boot = 3'd4;

	logic [1:0] state;
	logic [2:0] sel_now;
	logic [2:0] sel_q;
	logic [1:0] boot_cnt;
	logic [altair_bus_pkg::data_w-1:0] boot_q;
	altair_bus_pkg::bus_addr_t bus_addr;
	logic is_io;
	logic boot_active;
	logic tgt_ready;
	logic go;

	assign is_io = paddr[altair_bus_pkg::addr_w];
	assign bus_addr = paddr[altair_bus_pkg::addr_w-1:0];
	assign boot_active = (boot_cnt != 2'd3); // three jump bytes, then off

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	always_comb begin
		sel_now = sel_none;
		if (is_io) begin
			if ((bus_addr.io.port & altair_bus_pkg::acia_port_mask) ==
					altair_bus_pkg::acia_port_match)
				sel_now = sel_acia;
		end else if (boot_active && !pwrite) begin
			sel_now = sel_boot; // any address while the overlay is on
		end else if (bus_addr.mem.page[7:5] == altair_bus_pkg::main_page_prefix) begin
			sel_now = sel_main;
		end else if (bus_addr.mem.page == altair_bus_pkg::stack_page) begin
			sel_now = sel_stack;
		end
	end

	always_comb begin
		case (sel_now)
			sel_main:  tgt_ready = main_bus.ready;
			sel_stack: tgt_ready = stack_bus.ready;
			sel_acia:  tgt_ready = acia_bus.ready;
			default:   tgt_ready = 1'b1; // boot and unmapped never stall
		endcase
	end

	assign go = (state == st_wait) && tgt_ready;

	// strobes and address to the targets
	assign main_bus.addr = bus_addr[altair_bus_pkg::main_addr_w-1:0];
	assign stack_bus.addr = bus_addr.mem.offset;
	assign acia_bus.addr = bus_addr.io.port[0];
	assign main_bus.wdata = pwdata;
	assign stack_bus.wdata = pwdata;
	assign acia_bus.wdata = pwdata;
	assign main_bus.rd = go && !pwrite && (sel_now == sel_main);
	assign main_bus.we = go && pwrite && (sel_now == sel_main);
	assign stack_bus.rd = go && !pwrite && (sel_now == sel_stack);
	assign stack_bus.we = go && pwrite && (sel_now == sel_stack);
	assign acia_bus.rd = go && !pwrite && (sel_now == sel_acia);
	assign acia_bus.we = go && pwrite && (sel_now == sel_acia);

	// --------------------------------------------------
	// apb state machine and boot overlay
	// --------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			sel_q <= sel_none;
			boot_cnt <= 2'd0;
		end else begin
			case (state)
				st_idle: if (psel && !penable) state <= st_wait; // setup phase
				st_wait: begin
					if (tgt_ready) begin
						state <= st_resp;
						sel_q <= pwrite ? sel_none : sel_now;
						if (sel_now == sel_boot)
							boot_cnt <= boot_cnt + 2'd1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (go && sel_now == sel_boot)
			boot_q <= altair_bus_pkg::boot_bytes[boot_cnt];
	end

	assign pready = (state == st_resp);

	always_comb begin
		case (sel_q)
			sel_main:  prdata = main_bus.rdata;
			sel_stack: prdata = stack_bus.rdata;
			sel_acia:  prdata = acia_bus.rdata;
			sel_boot:  prdata = boot_q;
			default:   prdata = altair_bus_pkg::unmapped_data;
		endcase
	end

	// a data write must leave the serial port busy, or the next byte is lost
	assert property (@(posedge clk) disable iff (reset)
		(acia_bus.we && acia_bus.addr[0]) |=> !acia_bus.ready)
		else $error("bus_decoder: serial port still ready after a data write");

	// master holds the transfer steady until pready
	assert property (@(posedge clk) disable iff (reset)
		(state != st_idle) |-> (psel && $stable(paddr) && $stable(pwrite)))
		else $error("bus_decoder: apb transfer changed before pready");

endmodule

`default_nettype wire

// File: design/acia_6850.sv
`default_nettype none

module acia_6850 #(
	parameter int CLKS_PER_BIT = 16
) (
	input  wire logic   clk,
	input  wire logic   reset,
	local_bus_if.target bus,
	input  wire logic   rx,
	output wire logic   tx
);

	logic data_sel;
	logic tx_load;
	logic tx_busy;
	logic rx_valid;
	logic rx_clear;
	logic [altair_bus_pkg::data_w-1:0] tx_data;
	logic [altair_bus_pkg::data_w-1:0] rx_data;
	logic [altair_bus_pkg::data_w-1:0] status;

	assign data_sel = bus.addr[0]; // 0 status, 1 data

	// writes to the control register are ignored
	assign tx_load = bus.we && data_sel;
	assign tx_data = bus.wdata & altair_bus_pkg::ascii_mask; // 7-bit terminal
	assign rx_clear = bus.rd && data_sel;

	serial_uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart0 (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.tx       (tx),
		.tx_load  (tx_load),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.rx_clear (rx_clear)
	);

	// --------------------------------------------------
	// status byte and read register
	// --------------------------------------------------
	always_comb begin
		status = '0;
		status[altair_bus_pkg::stat_rx_full] = rx_valid;
		status[altair_bus_pkg::stat_rx_full_mirror] = rx_valid; // rdrf seen by basic
		status[altair_bus_pkg::stat_tx_empty] = !tx_busy;
	end

	always_ff @(posedge clk) begin
		if (bus.rd) begin
			if (data_sel)
				bus.rdata <= rx_data;
			else
				bus.rdata <= status;
		end
	end

	// stall the host while a frame is on the line
	assign bus.ready = !tx_busy;

endmodule

`default_nettype wire

// File: design/serial_uart.sv
`default_nettype none

// 8N1 transmitter and receiver, fixed bit time
module serial_uart #(
	parameter int CLKS_PER_BIT = 16
) (
	input  wire logic                              clk,
	input  wire logic                              reset,
	input  wire logic                              rx,
	output wire logic                              tx,
	input  wire logic                              tx_load,
	input  wire logic [altair_bus_pkg::data_w-1:0] tx_data,
	output wire logic                              tx_busy,
	output logic      [altair_bus_pkg::data_w-1:0] rx_data,
	output logic                                   rx_valid,
	input  wire logic                              rx_clear
);

	localparam int frame_w = altair_bus_pkg::data_w + 2; // start, data, stop
	localparam int cnt_w = $clog2(CLKS_PER_BIT);
	localparam logic [cnt_w-1:0] div_last = cnt_w'(CLKS_PER_BIT - 1);
	localparam logic [cnt_w-1:0] div_half = cnt_w'(CLKS_PER_BIT / 2 - 1);

	localparam logic [1:0] rx_idle = 2'd0;
	localparam logic [1:0] rx_start = 2'd1;
	localparam logic [1:0] rx_recv = 2'd2;
	localparam logic [1:0] rx_stop = 2'd3;

	logic [frame_w-1:0] tx_frame;
	logic [3:0] tx_bits;
	logic [cnt_w-1:0] tx_div;
	logic rx_meta;
	logic rx_sync;
	logic [1:0] rx_state;
	logic [cnt_w-1:0] rx_div;
	logic [2:0] rx_bits;
	logic [altair_bus_pkg::data_w-1:0] rx_shift;
	logic rx_tick;

	// --------------------------------------------------
	// transmitter
	// --------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_frame <= '1; // line idles high
			tx_bits <= 4'd0;
			tx_div <= '0;
		end else if (tx_bits != 4'd0) begin
			if (tx_div == div_last) begin
				tx_div <= '0;
				tx_frame <= {1'b1, tx_frame[frame_w-1:1]}; // lsb first
				tx_bits <= tx_bits - 4'd1;
			end else begin
				tx_div <= tx_div + cnt_w'(1);
			end
		end else if (tx_load) begin
			tx_frame <= {1'b1, tx_data, 1'b0};
			tx_bits <= 4'(frame_w);
			tx_div <= '0;
		end
	end

	assign tx = tx_frame[0];
	assign tx_busy = (tx_bits != 4'd0); // through the end of the stop bit

	// --------------------------------------------------
	// receiver
	// --------------------------------------------------
	assign rx_tick = (rx_div == div_last);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_state <= rx_idle;
			rx_div <= '0;
			rx_bits <= 3'd0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			if (rx_clear)
				rx_valid <= 1'b0; // a new byte below wins
			case (rx_state)
				rx_idle: begin
					rx_div <= '0;
					if (!rx_sync)
						rx_state <= rx_start;
				end
				rx_start: begin
					if (rx_div == div_half) begin // middle of start bit
						rx_div <= '0;
						rx_bits <= 3'd0;
						rx_state <= rx_sync ? rx_idle : rx_recv;
					end else begin
						rx_div <= rx_div + cnt_w'(1);
					end
				end
				rx_recv: begin
					if (rx_tick) begin
						rx_div <= '0;
						rx_bits <= rx_bits + 3'd1;
						if (rx_bits == 3'(altair_bus_pkg::data_w - 1))
							rx_state <= rx_stop;
					end else begin
						rx_div <= rx_div + cnt_w'(1);
					end
				end
				default: begin
					if (rx_tick) begin
						rx_state <= rx_idle;
						rx_valid <= 1'b1; // overwrites an unread byte
					end else begin
						rx_div <= rx_div + cnt_w'(1);
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_state == rx_recv && rx_tick)
			rx_shift <= {rx_sync, rx_shift[altair_bus_pkg::data_w-1:1]};
		if (rx_state == rx_stop && rx_tick)
			rx_data <= rx_shift;
	end

	// host must wait on ready before loading
	assert property (@(posedge clk) disable iff (reset) tx_load |-> !tx_busy)
		else $error("serial_uart: tx_load while a frame is in flight");

endmodule

`default_nettype wire

// File: design/sync_ram.sv
`default_nettype none

// byte wide ram, registered read port
module sync_ram #(
	parameter int ADDR_WIDTH = 8
) (
	input wire logic    clk,
	local_bus_if.target bus
);

	logic [altair_bus_pkg::data_w-1:0] mem [0:(2 ** ADDR_WIDTH)-1];

	always_ff @(posedge clk) begin
		if (bus.we)
			mem[bus.addr] <= bus.wdata;
		if (bus.rd)
			bus.rdata <= mem[bus.addr]; // held until next rd
	end

	assign bus.ready = 1'b1; // never stalls

endmodule

`default_nettype wire

// File: design/local_bus_if.sv
`default_nettype none

// one decoded transfer between the bus decoder and a single target
interface local_bus_if #(
	parameter int ADDR_WIDTH = 8
) ();

	logic [ADDR_WIDTH-1:0] addr;
	logic [altair_bus_pkg::data_w-1:0] wdata;
	logic rd; // one-cycle strobe, only while ready
	logic we;
	logic [altair_bus_pkg::data_w-1:0] rdata; // valid the cycle after rd
	logic ready;

	modport host (
		output addr, wdata, rd, we,
		input  rdata, ready
	);

	modport target (
		input  addr, wdata, rd, we,
		output rdata, ready
	);

endinterface

`default_nettype wire

// File: design/altair_bus_pkg.sv
`default_nettype none

package altair_bus_pkg;

	// --------------------------------------------------
	// bus widths
	// --------------------------------------------------
	localparam int addr_w = 16;
	localparam int data_w = 8;

	// one address word, seen as memory or as I/O
	typedef union packed {
		struct packed {
			logic [7:0] page;
			logic [7:0] offset;
		} mem;
		struct packed {
			logic [7:0] mirror; // 8080 repeats the port here
			logic [7:0] port;
		} io;
	} bus_addr_t;

	// --------------------------------------------------
	// memory and I/O map
	// --------------------------------------------------
	localparam logic [2:0] main_page_prefix = 3'b000; // 0x0000-0x1fff
	localparam int main_addr_w = 13;
	localparam logic [7:0] stack_page = 8'hfb;
	localparam int stack_addr_w = 8;

	// ports 0x00/0x01 and the mirror at 0x10/0x11
	localparam logic [7:0] acia_port_mask = 8'hee;
	localparam logic [7:0] acia_port_match = 8'h00;

	// turn-key jump to 0xfd00
	localparam logic [data_w-1:0] boot_bytes [0:2] = '{8'hc3, 8'h00, 8'hfd};
	localparam logic [data_w-1:0] unmapped_data = 8'hff;

	// serial status bits
	localparam int stat_rx_full = 0;
	localparam int stat_rx_full_mirror = 5;
	localparam int stat_tx_empty = 1;
	localparam logic [data_w-1:0] ascii_mask = 8'h7f;

endpackage

`default_nettype wire
